//--- vlog.f
io_map_pkg.sv
irq_pkg.sv
io_bus_if.sv
timer_unit.sv
pin_unit.sv
io_irq_hub.sv
io_subsystem.sv
tb_clock_gen.sv
tb_top.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top import io_map_pkg::*, irq_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  // Worst case per test: readback, port, pins, timer, ticks
  localparam int TEST_CYCLES = 30 + 10 + 70 + 90 + 60;
  localparam int TIMEOUT_NS  = 2 * (TEST_CYCLES + 10) * CLK_PERIOD;
  localparam bit [31:0] SEED = 32'hb600_88f5;
  localparam io_word_t UNMAPPED = 16'd200;
  localparam io_word_t RW_REGS [6] = '{REG_INT_MASK, REG_INT_FLAGS, REG_PORTA_OUT,
                                       REG_PORTA_DIR, REG_TIMER1C_L, REG_TIMER1C_H};

  logic clk, resetq, io_wr;
  io_word_t io_addr, io_wdata, porta_in, io_rdata, porta_out, porta_dir;
  ext_irq_vec_t intr;
  irq_vec_t int_rqst;

  // Expected values, each checked while its enable is high
  string test_name;
  logic chk_rd, chk_port, chk_rqst;
  io_word_t exp_rd, exp_out, exp_dir;
  irq_vec_t exp_rqst;
  int edge_cnt;

  tb_clock_gen u_clk (.clk(clk), .resetq(resetq));

  io_subsystem dut (
    .clk       (clk),
    .resetq    (resetq),
    .io_wr     (io_wr),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .porta_in  (porta_in),
    .intr      (intr),
    .io_rdata  (io_rdata),
    .porta_out (porta_out),
    .porta_dir (porta_dir),
    .int_rqst  (int_rqst)
  );

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(string what, io_word_t expected, io_word_t actual);
    $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, expected, actual);
    fail_run();
  endtask

  a_rdata: assert property (@(posedge clk) disable iff (!resetq) chk_rd |-> io_rdata == exp_rd)
    else mismatch("io_rdata", $sampled(exp_rd), $sampled(io_rdata));
  a_porta_out: assert property (@(posedge clk) disable iff (!resetq)
    chk_port |-> porta_out == exp_out)
    else mismatch("porta_out", $sampled(exp_out), $sampled(porta_out));
  a_porta_dir: assert property (@(posedge clk) disable iff (!resetq)
    chk_port |-> porta_dir == exp_dir)
    else mismatch("porta_dir", $sampled(exp_dir), $sampled(porta_dir));
  a_rqst: assert property (@(posedge clk) disable iff (!resetq) chk_rqst |-> int_rqst == exp_rqst)
    else mismatch("int_rqst", {8'h00, $sampled(exp_rqst)}, {8'h00, $sampled(int_rqst)});

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    fail_run();
  end

  // Inputs change 1 ns after the edge
  task automatic cycle();
    @(posedge clk);
    edge_cnt++;
    #1;
  endtask

  task automatic write_reg(io_word_t addr, io_word_t data);
    io_wr    = 1'b1;
    io_addr  = addr;
    io_wdata = data;
    cycle();
    io_wr = 1'b0;
  endtask

  task automatic expect_read(io_word_t addr, io_word_t value);
    io_addr = addr;
    exp_rd  = value;
    chk_rd  = 1'b1;
    cycle();
    chk_rd = 1'b0;
  endtask

  // Two synchroniser edges, then the pending flop
  task automatic raise_pin(int line);
    intr[line] = 1'b1;
    repeat (3) cycle();
    exp_rqst[line] = 1'b1;
  endtask

  task automatic clear_line(int line);
    write_reg(REG_INT_FLAGS, 16'h00ff & ~(16'h0001 << line));
    cycle();
    exp_rqst[line] = 1'b0;
    write_reg(REG_INT_FLAGS, 16'h00ff);
  endtask

  initial
  begin
    io_word_t wdata;
    logic [TICKS_WIDTH-1:0] first, second;
    int period, start_edge, gap;
    void'($urandom(SEED));
    {io_wr, io_addr, io_wdata, porta_in, intr} = '0;
    {chk_rd, chk_port, chk_rqst, exp_rd, exp_out, exp_dir, exp_rqst} = '0;
    edge_cnt  = 0;
    test_name = "reset";
    wait (resetq === 1'b1);
    cycle();

    test_name = "register readback";
    for (int r = 0; r < 6; r++)
    begin
      wdata = io_word_t'($urandom);
      write_reg(RW_REGS[r], wdata);
      if (RW_REGS[r] == REG_PORTA_OUT)
        exp_out = wdata;
      if (RW_REGS[r] == REG_PORTA_DIR)
        exp_dir = wdata;
      if (RW_REGS[r] == REG_INT_MASK || RW_REGS[r] == REG_INT_FLAGS)
        expect_read(RW_REGS[r], {8'h00, wdata[7:0]});
      else
        expect_read(RW_REGS[r], wdata);
    end
    expect_read(UNMAPPED, '0);
    // Stop the timer and drop anything the random values latched
    write_reg(REG_TIMER1C_L, '0);
    write_reg(REG_TIMER1C_H, '0);
    write_reg(REG_INT_FLAGS, '0);
    write_reg(REG_INT_FLAGS, 16'h00ff);
    write_reg(REG_INT_MASK, '0);

    test_name = "port input";
    chk_port  = 1'b1;
    repeat (8)
    begin
      porta_in = io_word_t'($urandom);
      expect_read(REG_PORTA_IN, porta_in);
    end

    test_name = "external interrupt";
    write_reg(REG_INT_MASK, 16'h000f);
    chk_rqst = 1'b1;
    for (int i = 0; i < NUM_EXT_IRQ; i++)
    begin
      raise_pin(i);
      clear_line(i);
      intr[i] = 1'b0;
      repeat (4) cycle();
    end
    test_name = "masked interrupt";
    write_reg(REG_INT_MASK, '0);
    intr[2] = 1'b1;
    repeat (6) cycle();
    write_reg(REG_INT_MASK, 16'h0004);
    exp_rqst[2] = 1'b1;
    cycle();
    clear_line(2);
    intr[2] = 1'b0;

    test_name = "timer period";
    period = $urandom_range(21, 6);
    write_reg(REG_INT_MASK, 16'h0080);
    write_reg(REG_TIMER1C_L, io_word_t'(period));
    write_reg(REG_TIMER1C_H, '0);
    start_edge = edge_cnt;
    for (int p = 1; p <= 3; p++)
    begin
      while (edge_cnt < start_edge + p * period)
        cycle();
      exp_rqst[IRQ_TIMER1] = 1'b1;
      clear_line(IRQ_TIMER1);
    end
    chk_rqst = 1'b0;
    write_reg(REG_TIMER1C_L, '0);

    test_name = "tick sampling";
    gap = $urandom_range(40, 10);
    write_reg(REG_TICKS_SAMPLE, '0);
    start_edge = edge_cnt;
    // Ticks counts from zero, so the sample edge sees one less than the edge count
    first = TICKS_WIDTH'(edge_cnt - 1);
    expect_read(REG_TICKSS_L, first[15:0]);
    expect_read(REG_TICKSS_H, first[31:16]);
    expect_read(REG_TICKSS_HH, first[47:32]);
    while (edge_cnt < start_edge + gap - 1)
      cycle();
    write_reg(REG_TICKS_SAMPLE, '0);
    second = first + 48'(gap);
    expect_read(REG_TICKSS_L, second[15:0]);
    expect_read(REG_TICKSS_H, second[31:16]);
    expect_read(REG_TICKSS_HH, second[47:32]);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic resetq
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release comes just after a rising edge
  initial
  begin
    resetq = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetq = 1'b1;
  end

endmodule

//--- io_subsystem.sv
`timescale 1ns/1ps

module io_subsystem import io_map_pkg::*, irq_pkg::*; (
  input  logic         clk,
  input  logic         resetq,
  input  logic         io_wr,
  input  io_word_t     io_addr,
  input  io_word_t     io_wdata,
  input  io_word_t     porta_in,
  input  ext_irq_vec_t intr,
  output io_word_t     io_rdata,
  output io_word_t     porta_out,
  output io_word_t     porta_dir,
  output irq_vec_t     int_rqst
);

  logic         timer1_expired;
  ext_irq_vec_t ext_edge;

  io_bus_if timer_bus ();
  io_bus_if pin_bus ();

  assign timer_bus.wr    = io_wr;
  assign timer_bus.addr  = io_reg_e'(io_addr);
  assign timer_bus.wdata = io_wdata;

  assign pin_bus.wr    = io_wr;
  assign pin_bus.addr  = io_reg_e'(io_addr);
  assign pin_bus.wdata = io_wdata;

  timer_unit u_timer (
    .clk            (clk),
    .resetq         (resetq),
    .bus            (timer_bus),
    .timer1_expired (timer1_expired)
  );

  pin_unit u_pin (
    .clk       (clk),
    .resetq    (resetq),
    .porta_in  (porta_in),
    .intr      (intr),
    .bus       (pin_bus),
    .porta_out (porta_out),
    .porta_dir (porta_dir),
    .ext_edge  (ext_edge)
  );

  io_irq_hub u_hub (
    .clk            (clk),
    .resetq         (resetq),
    .io_wr          (io_wr),
    .io_addr        (io_reg_e'(io_addr)),
    .io_wdata       (io_wdata),
    .timer1_expired (timer1_expired),
    .ext_edge       (ext_edge),
    .timer_rd       (timer_bus),
    .pin_rd         (pin_bus),
    .io_rdata       (io_rdata),
    .int_rqst       (int_rqst)
  );

endmodule

//--- io_irq_hub.sv
`timescale 1ns/1ps

module io_irq_hub import io_map_pkg::*, irq_pkg::*; (
  input  logic         clk,
  input  logic         resetq,
  input  logic         io_wr,
  input  io_reg_e      io_addr,
  input  io_word_t     io_wdata,
  input  logic         timer1_expired,
  input  ext_irq_vec_t ext_edge,
  io_bus_if.merge      timer_rd,
  io_bus_if.merge      pin_rd,
  output io_word_t     io_rdata,
  output irq_vec_t     int_rqst
);

  irq_vec_t pending;
  irq_vec_t mask;
  irq_vec_t flags;
  irq_vec_t irq_set;
  logic     mask_wr;
  logic     flags_wr;
  io_word_t hub_rdata;

  assign mask_wr  = io_wr && (io_addr == REG_INT_MASK);
  assign flags_wr = io_wr && (io_addr == REG_INT_FLAGS);

  // Lines 4 to 6 have no source
  always_comb
  begin
    irq_set                  = '0;
    irq_set[NUM_EXT_IRQ-1:0] = ext_edge;
    irq_set[IRQ_TIMER1]      = timer1_expired;
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      pending <= '0;
      mask    <= '0;
      flags   <= FLAGS_RESET;
    end
    else
    begin
      // A new event wins over a clear in the same cycle
      pending <= irq_set | (pending & flags);
      if (mask_wr)
        mask <= io_wdata[NUM_IRQ-1:0];
      if (flags_wr)
        flags <= io_wdata[NUM_IRQ-1:0];
    end
  end

  assign int_rqst = pending & mask;

  always_comb
  begin
    case (io_addr)
      REG_INT_FLAGS: hub_rdata = {{(IO_WIDTH-NUM_IRQ){1'b0}}, flags};
      REG_INT_MASK:  hub_rdata = {{(IO_WIDTH-NUM_IRQ){1'b0}}, mask};
      default:       hub_rdata = '0;
    endcase
  end

  // Each source returns zero off its own addresses
  assign io_rdata = hub_rdata | timer_rd.rdata | pin_rd.rdata;

  // A request only rises on an enabled line, after an event or a mask write
  for (genvar i = 0; i < NUM_IRQ; i++)
  begin : g_rqst_chk
    a_rqst_src: assert property (@(posedge clk) disable iff (!resetq)
      $rose(int_rqst[i]) |-> mask[i] && ($past(irq_set[i]) || $past(mask_wr)));
  end

endmodule

//--- pin_unit.sv
`timescale 1ns/1ps

module pin_unit import io_map_pkg::*, irq_pkg::*; (
  input  logic         clk,
  input  logic         resetq,
  input  io_word_t     porta_in,
  input  ext_irq_vec_t intr,
  io_bus_if.unit       bus,
  output io_word_t     porta_out,
  output io_word_t     porta_dir,
  output ext_irq_vec_t ext_edge
);

  // Stage 0 samples the pins, the last stage is the oldest
  ext_irq_vec_t sync_q [SYNC_STAGES];

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      porta_out <= '0;
      porta_dir <= '0;
    end
    else if (bus.wr)
    begin
      if (bus.addr == REG_PORTA_OUT)
        porta_out <= bus.wdata;
      // 1 drives the pin, 0 leaves it as input
      if (bus.addr == REG_PORTA_DIR)
        porta_dir <= bus.wdata;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      for (int s = 0; s < SYNC_STAGES; s++)
        sync_q[s] <= '0;
    end
    else
    begin
      sync_q[0] <= intr;
      for (int s = 1; s < SYNC_STAGES; s++)
        sync_q[s] <= sync_q[s-1];
    end
  end

  // Rising edge seen between the two oldest stages
  assign ext_edge = sync_q[SYNC_STAGES-2] & ~sync_q[SYNC_STAGES-1];

  always_comb
  begin
    case (bus.addr)
      REG_PORTA_IN:  bus.rdata = porta_in;
      REG_PORTA_OUT: bus.rdata = porta_out;
      REG_PORTA_DIR: bus.rdata = porta_dir;
      default:       bus.rdata = '0;
    endcase
  end

  // The newest-but-one stage holds the pin as sampled two edges earlier
  for (genvar i = 0; i < NUM_EXT_IRQ; i++)
  begin : g_edge_chk
    a_edge_src: assert property (@(posedge clk) disable iff (!resetq)
      ext_edge[i] |-> $past(intr[i], 2));
  end

endmodule

//--- timer_unit.sv
`timescale 1ns/1ps

module timer_unit import io_map_pkg::*; (
  input  logic   clk,
  input  logic   resetq,
  io_bus_if.unit bus,
  output logic   timer1_expired
);

  logic [TICKS_WIDTH-1:0]  ticks;
  logic [TICKS_WIDTH-1:0]  ticks_sample;
  logic [TIMER1_WIDTH-1:0] reload;
  logic [TIMER1_WIDTH-1:0] count;
  logic [TIMER1_WIDTH-1:0] reload_next;
  logic                    sample_wr;
  logic                    reload_lo_wr;
  logic                    reload_hi_wr;

  assign sample_wr    = bus.wr && (bus.addr == REG_TICKS_SAMPLE);
  assign reload_lo_wr = bus.wr && (bus.addr == REG_TIMER1C_L);
  assign reload_hi_wr = bus.wr && (bus.addr == REG_TIMER1C_H);

  // Writing the high half arms the timer with the full new value
  assign reload_next = {bus.wdata, reload[IO_WIDTH-1:0]};

  assign timer1_expired = (count == 1);

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      ticks        <= '0;
      ticks_sample <= '0;
    end
    else
    begin
      ticks <= ticks + 1'b1;
      if (sample_wr)
        ticks_sample <= ticks;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetq)
    begin
      reload <= '0;
      count  <= '0;
    end
    else
    begin
      if (reload_lo_wr)
        reload[IO_WIDTH-1:0] <= bus.wdata;
      if (reload_hi_wr)
        reload[TIMER1_WIDTH-1:IO_WIDTH] <= bus.wdata;

      if (reload_hi_wr)
        count <= reload_next;
      else if (reload == 0)
        count <= '0;
      // Reload on expiry gives a period of exactly reload cycles
      else if (timer1_expired)
        count <= reload;
      else
        count <= count - 1'b1;
    end
  end

  always_comb
  begin
    case (bus.addr)
      REG_TICKSS_L:  bus.rdata = ticks_sample[IO_WIDTH-1:0];
      REG_TICKSS_H:  bus.rdata = ticks_sample[2*IO_WIDTH-1:IO_WIDTH];
      REG_TICKSS_HH: bus.rdata = ticks_sample[TICKS_WIDTH-1:2*IO_WIDTH];
      REG_TIMER1C_L: bus.rdata = reload[IO_WIDTH-1:0];
      REG_TIMER1C_H: bus.rdata = reload[TIMER1_WIDTH-1:IO_WIDTH];
      default:       bus.rdata = '0;
    endcase
  end

  // Expiry is a single-cycle pulse
  a_expired_pulse: assert property (@(posedge clk) disable iff (!resetq)
    timer1_expired |=> !timer1_expired);

endmodule

//--- io_bus_if.sv
`timescale 1ns/1ps

interface io_bus_if import io_map_pkg::*; ();

  logic     wr;
  io_reg_e  addr;
  io_word_t wdata;
  // Zero unless addr hits one of the unit's registers
  io_word_t rdata;

  modport unit (
    input  wr,
    input  addr,
    input  wdata,
    output rdata
  );

  modport merge (
    input  rdata
  );

endinterface

//--- irq_pkg.sv
package irq_pkg;

  // Interrupt lines into the CPU
  localparam int NUM_IRQ = 8;

  // External pins occupy lines 0 to NUM_EXT_IRQ-1
  localparam int NUM_EXT_IRQ = 4;

  // Line of the periodic timer, highest priority
  localparam int IRQ_TIMER1 = 7;

  // Flops between a pin and its edge detector
  localparam int SYNC_STAGES = 3;

  typedef logic [NUM_IRQ-1:0]     irq_vec_t;
  typedef logic [NUM_EXT_IRQ-1:0] ext_irq_vec_t;

  // Flags start set so that no pending line is cleared by accident
  localparam irq_vec_t FLAGS_RESET = '1;

endpackage

//--- io_map_pkg.sv
package io_map_pkg;

  // CPU data word
  localparam int IO_WIDTH = 16;

  typedef logic [IO_WIDTH-1:0] io_word_t;

  // I/O register addresses as seen from the CPU
  typedef enum logic [IO_WIDTH-1:0] {
    REG_INT_FLAGS    = 16'd40,
    REG_INT_MASK     = 16'd50,
    REG_TICKSS_L     = 16'd105,
    REG_TICKSS_H     = 16'd106,
    REG_TICKSS_HH    = 16'd107,
    // A write here takes a snapshot of the tick counter
    REG_TICKS_SAMPLE = 16'd109,
    REG_TIMER1C_L    = 16'd110,
    REG_TIMER1C_H    = 16'd111,
    REG_PORTA_IN     = 16'd310,
    REG_PORTA_OUT    = 16'd311,
    REG_PORTA_DIR    = 16'd312
  } io_reg_e;

  // Free-running tick counter, read back as three words
  localparam int TICKS_WIDTH = 48;

  // Periodic timer 1, reload written as two half-words
  localparam int TIMER1_WIDTH = 32;

endpackage
